/* list.f */
+incdir+.
fpu_pkg.sv
fpu_result_if.sv
fpu_noncomp_slice.sv
fpu_result_arbiter.sv
fpu_opgroup_block.sv
tb_fpu_opgroup_block.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       := tb_fpu_opgroup_block
FILELIST  := list.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search the log for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tb_fpu_opgroup_block.sv */
/*
 * Testbench of the FPU non-computational operation group
 * Table-driven requests, random back-pressure, tag-matched scoreboard
 */

`timescale 1ns/1ns

module tb_fpu_opgroup_block import fpu_pkg::*; ();

  localparam int NUM_ENTRIES = 16;
  localparam int TIMEOUT     = 200;
  localparam status_t NV     = 5'h10;

  logic       clk_i = 1'b0;
  logic       rst_n_i, flush_i, in_valid_i, in_ready_o;
  fpu_word_t  op_a_i, op_b_i, result_o;
  operation_e op_i;
  roundmode_e rnd_mode_i;
  fp_format_e fp_fmt_i;
  fpu_tag_t   tag_i, tag_o;
  status_t    status_o;
  logic       extension_bit_o, out_valid_o, busy_o;
  logic       out_ready_i = 1'b0;

  // Stimulus and expected values, one slot per tag
  fp_format_e fmt_t  [NUM_ENTRIES];
  operation_e op_t   [NUM_ENTRIES];
  roundmode_e rm_t   [NUM_ENTRIES];
  fpu_word_t  a_t    [NUM_ENTRIES];
  fpu_word_t  b_t    [NUM_ENTRIES];
  fpu_word_t  exp_res[NUM_ENTRIES];
  status_t    exp_st [NUM_ENTRIES];
  logic       exp_ext[NUM_ENTRIES];

  bit     issued [NUM_ENTRIES];
  bit     done   [NUM_ENTRIES];
  int     done_cnt, num_filled, pass_cnt, fail_cnt;
  bit     hold_ready, timed_out;
  integer seed = 32'hafbdbe6e;

  fpu_opgroup_block u_dut (.*);

  always #2 clk_i = ~clk_i;

  // Random output back-pressure, forced low while holding
  always @(negedge clk_i) begin
    out_ready_i <= hold_ready ? 1'b0 : (($random(seed) % 4) != 0);
  end

  task automatic add_entry(input fp_format_e fmt, input operation_e op, input roundmode_e rm,
                           input fpu_word_t a, input fpu_word_t b, input fpu_word_t res,
                           input status_t st, input logic ext);
    fmt_t[num_filled]   = fmt;
    op_t[num_filled]    = op;
    rm_t[num_filled]    = rm;
    a_t[num_filled]     = a;
    b_t[num_filled]     = b;
    exp_res[num_filled] = res;
    exp_st[num_filled]  = st;
    exp_ext[num_filled] = ext;
    num_filled++;
  endtask

  task automatic report_test(input string name, input bit ok);
    if (ok) begin
      pass_cnt++;
      $display("ok    %s", name);
    end else begin
      fail_cnt++;
      $display("FAIL  %s", name);
    end
  endtask

  // Remaining steps are skipped once a wait has expired
  task automatic flag_timeout(input string reason);
    $display("%s", reason);
    fail_cnt++;
    timed_out = 1'b1;
  endtask

  task automatic clear_scoreboard();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      issued[i] = 1'b0;
      done[i]   = 1'b0;
    end
    done_cnt = 0;
  endtask

  // --------------------------------------------------
  // Scoreboard, sampled at the transfer edge
  // --------------------------------------------------
  task automatic check_result();
    int t;
    bit ok;
    t  = int'(tag_o);
    ok = 1'b1;
    assert (issued[t] && !done[t]) else begin
      $display("Result with tag %0d was not expected or arrived twice", t);
      ok = 1'b0;
    end
    if (ok) begin
      assert (result_o == exp_res[t]) else begin
        $display("MISMATCH at %0t: tag %0d result %h, expected %h",
                 $time, t, result_o, exp_res[t]);
        ok = 1'b0;
      end
      assert (status_o == exp_st[t]) else begin
        $display("MISMATCH at %0t: tag %0d status %b, expected %b",
                 $time, t, status_o, exp_st[t]);
        ok = 1'b0;
      end
      assert (extension_bit_o == exp_ext[t]) else begin
        $display("MISMATCH at %0t: tag %0d ext bit %b, expected %b",
                 $time, t, extension_bit_o, exp_ext[t]);
        ok = 1'b0;
      end
      done[t] = 1'b1;
      done_cnt++;
    end
    report_test($sformatf("entry %0d", t), ok);
  endtask

  always @(posedge clk_i) begin
    if (rst_n_i && out_valid_o && out_ready_i) begin
      check_result();
    end
  end

  task automatic issue_entry(input int idx, input bit expected);
    int cnt;
    bit accepted;
    if (timed_out) return;
    @(negedge clk_i);
    fp_fmt_i   = fmt_t[idx];
    op_i       = op_t[idx];
    rnd_mode_i = rm_t[idx];
    op_a_i     = a_t[idx];
    op_b_i     = b_t[idx];
    tag_i      = fpu_tag_t'(idx);
    in_valid_i = 1'b1;
    cnt        = 0;
    accepted   = 1'b0;
    while (!accepted && cnt < TIMEOUT) begin
      @(posedge clk_i);
      accepted = in_ready_o;
      cnt++;
    end
    if (!accepted) begin
      flag_timeout($sformatf("Timeout: in_ready_o never rose for entry %0d", idx));
    end else if (expected) begin
      issued[idx] = 1'b1;
    end
  endtask

  task automatic wait_all_done(input int n);
    int cnt;
    if (timed_out) return;
    cnt = 0;
    while (done_cnt < n && cnt < TIMEOUT) begin
      @(negedge clk_i);
      cnt++;
    end
    if (done_cnt < n) begin
      flag_timeout($sformatf("Timeout: only %0d of %0d results came out", done_cnt, n));
    end
  endtask

  task automatic check_idle(input string name);
    bit ok;
    if (timed_out) return;
    ok = 1'b1;
    assert (!out_valid_o && !busy_o) else begin
      $display("MISMATCH at %0t: out_valid_o %b busy_o %b, expected both low",
               $time, out_valid_o, busy_o);
      ok = 1'b0;
    end
    report_test(name, ok);
  endtask

  initial begin
    rst_n_i    = 1'b0;
    flush_i    = 1'b0;
    in_valid_i = 1'b0;
    op_a_i     = '0;
    op_b_i     = '0;
    op_i       = MINMAX;
    rnd_mode_i = RNE;
    fp_fmt_i   = FP32;
    tag_i      = '0;
    hold_ready = 1'b0;
    timed_out  = 1'b0;
    num_filled = 0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    clear_scoreboard();

    // Min/max: plain, signed zeros, one qNaN, sNaN, unboxed FP16
    add_entry(FP32, MINMAX, RNE, 32'h3f800000, 32'h40000000, 32'h3f800000, '0, 1'b0);
    add_entry(FP32, MINMAX, RTZ, 32'h80000000, 32'h00000000, 32'h00000000, '0, 1'b0);
    add_entry(FP32, MINMAX, RNE, 32'h7fc00000, 32'h40400000, 32'h40400000, '0, 1'b0);
    add_entry(FP32, MINMAX, RTZ, 32'h7f800001, 32'h7fc00000, 32'h7fc00000, NV, 1'b0);
    add_entry(FP16, MINMAX, RNE, 32'hffff3c00, 32'hffffc000, 32'hffffc000, '0, 1'b0);
    add_entry(FP16, MINMAX, RTZ, 32'h00003c00, 32'hffff4200, 32'hffff4200, '0, 1'b0);
    add_entry(FP16, MINMAX, RNE, 32'hffff7c01, 32'hffff3c00, 32'hffff3c00, NV, 1'b0);
    // Sign injection
    add_entry(FP32, SGNJ, RNE, 32'h3f800000, 32'hc0000000, 32'hbf800000, '0, 1'b0);
    add_entry(FP32, SGNJ, RTZ, 32'hbf800000, 32'hc0000000, 32'h3f800000, '0, 1'b0);
    add_entry(FP16, SGNJ, RDN, 32'hffffbc00, 32'hffffc000, 32'hffff3c00, '0, 1'b0);
    add_entry(FP16, SGNJ, RTZ, 32'hffff3c00, 32'hffff4000, 32'hffffbc00, '0, 1'b0);
    // Compare, results unboxed with ext bit
    add_entry(FP32, CMP, RNE, 32'h3f800000, 32'h3f800000, 32'h00000001, '0, 1'b1);
    add_entry(FP32, CMP, RTZ, 32'h40000000, 32'h3f800000, 32'h00000000, '0, 1'b1);
    add_entry(FP32, CMP, RDN, 32'h7fc00000, 32'h3f800000, 32'h00000000, '0, 1'b1);
    add_entry(FP16, CMP, RTZ, 32'hffff7e00, 32'hffff3c00, 32'h00000000, NV, 1'b1);
    add_entry(FP16, CMP, RDN, 32'hffff8000, 32'hffff0000, 32'h00000001, '0, 1'b1);

    repeat (2) @(negedge clk_i);
    rst_n_i = 1'b1;

    // Mixed formats under random back-pressure
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      issue_entry(i, 1'b1);
    end
    @(negedge clk_i);
    in_valid_i = 1'b0;
    wait_all_done(NUM_ENTRIES);
    check_idle("all tags drained, busy low");

    // --------------------------------------------------
    // Flush with a stalled output
    // --------------------------------------------------
    @(posedge clk_i);
    hold_ready = 1'b1;
    clear_scoreboard();
    issue_entry(0, 1'b0);
    issue_entry(4, 1'b0);
    issue_entry(1, 1'b0);
    @(negedge clk_i);
    in_valid_i = 1'b0;
    flush_i    = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    check_idle("flush empties the pipelines");

    @(posedge clk_i);
    hold_ready = 1'b0;
    issue_entry(11, 1'b1);
    @(negedge clk_i);
    in_valid_i = 1'b0;
    wait_all_done(1);
    check_idle("idle after post-flush request");

    $display("Tests: %0d ok, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* fpu_opgroup_block.sv */
/*
 * Non-computational operation group of the FPU
 * Steers requests to per-format slices and merges their results
 */

`timescale 1ns/1ns
`include "fpu_consts.svh"

module fpu_opgroup_block import fpu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       flush_i,
  // Request
  input  fpu_word_t  op_a_i,
  input  fpu_word_t  op_b_i,
  input  operation_e op_i,
  input  roundmode_e rnd_mode_i,
  input  fp_format_e fp_fmt_i,
  input  fpu_tag_t   tag_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  // Result
  output fpu_word_t  result_o,
  output status_t    status_o,
  output logic       extension_bit_o,
  output fpu_tag_t   tag_o,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output logic       busy_o
);

  localparam int unsigned N = `FPU_NUM_FMTS;

  logic [N-1:0] slice_valid, slice_ready, slice_busy;

  fpu_result_if res_if [N] ();

  // --------------------------------------------------
  // Format slices
  // --------------------------------------------------
  for (genvar f = 0; f < N; f++) begin : gen_slice
    localparam fp_format_e  FMT   = fp_format_e'(f);
    localparam int unsigned DEPTH = (FMT == FP32) ? `FPU_FP32_PIPE : `FPU_FP16_PIPE;

    // Only the addressed format sees the request
    assign slice_valid[f] = in_valid_i & (fp_fmt_i == FMT);

    fpu_noncomp_slice #(
      .Format      (FMT),
      .NumPipeRegs (DEPTH)
    ) u_slice (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .flush_i    (flush_i),
      .op_a_i     (op_a_i),
      .op_b_i     (op_b_i),
      .op_i       (op_i),
      .rnd_mode_i (rnd_mode_i),
      .tag_i      (tag_i),
      .in_valid_i (slice_valid[f]),
      .in_ready_o (slice_ready[f]),
      .busy_o     (slice_busy[f]),
      .res        (res_if[f])
    );
  end

  assign in_ready_o = in_valid_i & slice_ready[fp_fmt_i];
  assign busy_o     = |slice_busy;

  // --------------------------------------------------
  // Output merge
  // --------------------------------------------------
  fpu_result_arbiter u_arbiter (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .flush_i   (flush_i),
    .slv       (res_if),
    .result_o  (result_o),
    .status_o  (status_o),
    .ext_bit_o (extension_bit_o),
    .tag_o     (tag_o),
    .valid_o   (out_valid_o),
    .ready_i   (out_ready_i)
  );

endmodule

/* fpu_result_arbiter.sv */
/*
 * Flushable round-robin arbiter for slice results
 * Locks its grant while an offered transfer is back-pressured
 */

`timescale 1ns/1ns
`include "fpu_consts.svh"

module fpu_result_arbiter import fpu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       flush_i,
  fpu_result_if.sink slv [`FPU_NUM_FMTS],
  output fpu_word_t  result_o,
  output status_t    status_o,
  output logic       ext_bit_o,
  output fpu_tag_t   tag_o,
  output logic       valid_o,
  input  logic       ready_i
);

  localparam int unsigned N     = `FPU_NUM_FMTS;
  localparam int unsigned IDX_W = (N > 1) ? $clog2(N) : 1;

  logic [N-1:0]     req, gnt;
  fpu_word_t        result_arr [N];
  status_t          status_arr [N];
  logic [N-1:0]     ext_arr;
  fpu_tag_t         tag_arr    [N];
  logic [IDX_W-1:0] rr_q, rr_sel, sel, sel_q;
  logic             lock_q;

  for (genvar i = 0; i < N; i++) begin : gen_port
    assign req[i]        = slv[i].valid;
    assign result_arr[i] = slv[i].result;
    assign status_arr[i] = slv[i].status;
    assign ext_arr[i]    = slv[i].ext_bit;
    assign tag_arr[i]    = slv[i].tag;
    assign gnt[i]        = valid_o & ready_i & (sel == IDX_W'(i));
    assign slv[i].ready  = gnt[i];
  end

  // First requester at or after the pointer
  always_comb begin : rr_search
    int unsigned idx;
    logic        found;
    rr_sel = rr_q;
    found  = 1'b0;
    for (int unsigned k = 0; k < N; k++) begin
      idx = (int'(rr_q) + k) % N;
      if (!found && req[idx]) begin
        rr_sel = IDX_W'(idx);
        found  = 1'b1;
      end
    end
  end

  assign sel     = lock_q ? sel_q : rr_sel;
  assign valid_o = req[sel];

  assign result_o  = result_arr[sel];
  assign status_o  = status_arr[sel];
  assign ext_bit_o = ext_arr[sel];
  assign tag_o     = tag_arr[sel];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      rr_q   <= '0;
      sel_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      sel_q  <= sel;
      lock_q <= valid_o & ~ready_i;
      if (valid_o && ready_i) begin
        rr_q <= (sel == IDX_W'(N-1)) ? '0 : sel + 1'b1;
      end
    end
  end

  a_one_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt));

  a_tag_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i && !flush_i |=> valid_o && $stable(tag_o));

endmodule

/* fpu_noncomp_slice.sv */
/*
 * Non-computational slice for one format
 * Min/max, sign injection and compare, then an elastic pipeline
 */

`timescale 1ns/1ns
`include "fpu_consts.svh"

module fpu_noncomp_slice import fpu_pkg::*; #(
  parameter fp_format_e  Format      = FP32,
  parameter int unsigned NumPipeRegs = `FPU_FP32_PIPE
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       flush_i,
  input  fpu_word_t  op_a_i,
  input  fpu_word_t  op_b_i,
  input  operation_e op_i,
  input  roundmode_e rnd_mode_i,
  input  fpu_tag_t   tag_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  output logic       busy_o,
  fpu_result_if.src  res
);

  localparam int unsigned WORD_W = `FPU_WIDTH;
  localparam int unsigned FP_W   = (Format == FP32) ? 32 : 16;
  localparam int unsigned EXP_W  = (Format == FP32) ? 8 : 5;
  localparam int unsigned MAN_W  = FP_W - EXP_W - 1;
  localparam int unsigned PAY_W  = WORD_W + $bits(status_t) + 1 + `FPU_TAG_W;

  localparam logic [FP_W-1:0] QNAN = {1'b0, {EXP_W{1'b1}}, 1'b1, {(MAN_W-1){1'b0}}};

  typedef logic [PAY_W-1:0] payload_t;

  logic [FP_W-1:0] a_val, b_val, fp_res;
  fpu_word_t       fp_word, res_word;
  logic            a_nan, b_nan, a_snan, b_snan, any_nan, any_snan;
  logic            mag_lt, mag_eq, both_zero, a_lt_b, cmp_eq, cmp_lt;
  logic            is_cmp, cmp_bit, sgn;
  status_t         status;

  // --------------------------------------------------
  // Operand unpacking and output boxing
  // --------------------------------------------------
  if (Format == FP16) begin : gen_boxed
    // Improperly boxed operands read as the canonical NaN
    assign a_val   = (&op_a_i[WORD_W-1:FP_W]) ? op_a_i[FP_W-1:0] : QNAN;
    assign b_val   = (&op_b_i[WORD_W-1:FP_W]) ? op_b_i[FP_W-1:0] : QNAN;
    assign fp_word = {{(WORD_W-FP_W){1'b1}}, fp_res};
  end else begin : gen_native
    assign a_val   = op_a_i;
    assign b_val   = op_b_i;
    assign fp_word = fp_res;
  end

  assign a_nan    = (&a_val[FP_W-2:MAN_W]) & (|a_val[MAN_W-1:0]);
  assign b_nan    = (&b_val[FP_W-2:MAN_W]) & (|b_val[MAN_W-1:0]);
  assign a_snan   = a_nan & ~a_val[MAN_W-1];
  assign b_snan   = b_nan & ~b_val[MAN_W-1];
  assign any_nan  = a_nan | b_nan;
  assign any_snan = a_snan | b_snan;

  // Sign-magnitude ordering, -0 sorts below +0
  assign mag_lt    = a_val[FP_W-2:0] < b_val[FP_W-2:0];
  assign mag_eq    = a_val[FP_W-2:0] == b_val[FP_W-2:0];
  assign both_zero = ~|{a_val[FP_W-2:0], b_val[FP_W-2:0]};
  assign a_lt_b    = (a_val[FP_W-1] != b_val[FP_W-1]) ? a_val[FP_W-1] :
                     (a_val[FP_W-1] ? ~(mag_lt | mag_eq) : mag_lt);

  // Compare treats the two zeros as equal
  assign cmp_eq = (a_val == b_val) | both_zero;
  assign cmp_lt = a_lt_b & ~both_zero;

  always_comb begin
    fp_res  = a_val;
    status  = '0;
    is_cmp  = 1'b0;
    cmp_bit = 1'b0;
    sgn     = b_val[FP_W-1];
    case (op_i)
      MINMAX: begin
        status[STATUS_NV] = any_snan;
        if (a_nan && b_nan) begin
          fp_res = QNAN;
        end else if (a_nan) begin
          fp_res = b_val;
        end else if (b_nan) begin
          fp_res = a_val;
        end else if (rnd_mode_i == RTZ) begin
          fp_res = a_lt_b ? b_val : a_val;
        end else begin
          fp_res = a_lt_b ? a_val : b_val;
        end
      end
      SGNJ: begin
        case (rnd_mode_i)
          RNE:     sgn = b_val[FP_W-1];
          RTZ:     sgn = ~b_val[FP_W-1];
          default: sgn = a_val[FP_W-1] ^ b_val[FP_W-1];
        endcase
        fp_res = {sgn, a_val[FP_W-2:0]};
      end
      CMP: begin
        is_cmp = 1'b1;
        case (rnd_mode_i)
          RNE: begin
            cmp_bit           = ~any_nan & (cmp_lt | cmp_eq);
            status[STATUS_NV] = any_nan;
          end
          RTZ: begin
            cmp_bit           = ~any_nan & cmp_lt;
            status[STATUS_NV] = any_nan;
          end
          default: begin
            // Quiet NaNs compare unequal without a flag
            cmp_bit           = ~any_nan & cmp_eq;
            status[STATUS_NV] = any_snan;
          end
        endcase
      end
      default: ;
    endcase
  end

  // Compare results are plain integers, never boxed
  assign res_word = is_cmp ? WORD_W'(cmp_bit) : fp_word;

  // --------------------------------------------------
  // Elastic pipeline
  // --------------------------------------------------
  logic [NumPipeRegs-1:0] valid_q;
  logic [NumPipeRegs:0]   ready_s;
  payload_t               pay_q [NumPipeRegs];

  for (genvar s = 0; s < NumPipeRegs; s++) begin : gen_stage
    logic     up_valid;
    payload_t up_pay;

    if (s == 0) begin : gen_head
      assign up_valid = in_valid_i;
      assign up_pay   = {res_word, status, is_cmp, tag_i};
    end else begin : gen_link
      assign up_valid = valid_q[s-1];
      assign up_pay   = pay_q[s-1];
    end

    // Take new data when empty or when the content moves on
    assign ready_s[s] = ~valid_q[s] | ready_s[s+1];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i || flush_i) begin
        valid_q[s] <= 1'b0;
      end else if (ready_s[s]) begin
        valid_q[s] <= up_valid;
      end
    end

    always_ff @(posedge clk_i) begin
      if (ready_s[s] && up_valid) begin
        pay_q[s] <= up_pay;
      end
    end
  end

  assign ready_s[NumPipeRegs] = res.ready;
  assign in_ready_o           = ready_s[0];
  assign busy_o               = |valid_q;

  assign res.valid = valid_q[NumPipeRegs-1];
  assign {res.result, res.status, res.ext_bit, res.tag} = pay_q[NumPipeRegs-1];

  // Offered result must wait unchanged for the arbiter
  a_hold_payload: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res.valid && !res.ready && !flush_i |=>
      res.valid && $stable({res.result, res.status, res.ext_bit, res.tag}));

endmodule

/* fpu_result_if.sv */
/*
 * Result channel of one format slice
 * Carries the result record with a valid/ready handshake
 */

`timescale 1ns/1ns

interface fpu_result_if import fpu_pkg::*; ();

  fpu_word_t result;
  status_t   status;
  logic      ext_bit;
  fpu_tag_t  tag;
  logic      valid;
  logic      ready;

  // Slice side, payload held until the transfer
  modport src (
    output result, status, ext_bit, tag, valid,
    input  ready
  );

  // Arbiter side
  modport sink (
    input  result, status, ext_bit, tag, valid,
    output ready
  );

endinterface

/* fpu_pkg.sv */
/*
 * FPU non-computational group types
 * Formats, operations, sub-operation selector and status flags
 */

`include "fpu_consts.svh"

package fpu_pkg;

  typedef logic [`FPU_WIDTH-1:0] fpu_word_t;
  typedef logic [`FPU_TAG_W-1:0] fpu_tag_t;

  // Also the slice index
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic [1:0] {
    MINMAX,
    SGNJ,
    CMP
  } operation_e;

  // Doubles as the sub-operation select
  // MINMAX: RNE min, RTZ max
  // SGNJ:   RNE sign, RTZ negated sign, RDN xor of signs
  // CMP:    RNE le, RTZ lt, RDN eq
  typedef enum logic [1:0] {
    RNE,
    RTZ,
    RDN
  } roundmode_e;

  // Flag order from msb: NV DZ OF UF NX
  typedef logic [4:0] status_t;

  // Invalid operation flag position
  localparam int unsigned STATUS_NV = 4;

endpackage

/* fpu_consts.svh */
/*
 * FPU non-computational group constants
 * Data and tag widths, format count, default pipeline depths per format
 */

`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// Operand and result word
`define FPU_WIDTH 32

// Tag carried alongside each operation
`define FPU_TAG_W 4

// FP32 and FP16
`define FPU_NUM_FMTS 2

// Default stage counts of the format slices
`define FPU_FP32_PIPE 2
`define FPU_FP16_PIPE 1

`endif
